/* rtl/cfft_pkg.sv */
`default_nettype none

package cfft_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////
   localparam int DATA_W    = 32;
   localparam int HALF_W    = 16;             // one q1.15 part
   localparam int FRAC_BITS = 15;
   localparam int ADDR_W    = 8;
   localparam int INST_W    = 32;
   localparam int PLEN_W    = ADDR_W + 1;     // lengths 1..256
   localparam int WB_ADR_W  = 10;
   localparam int PIPE_LAT  = 4;              // issue to write-back

   // operation, bits 7:5 of the opcode byte
   localparam logic [2:0] OP_NOP    = 3'b000;
   localparam logic [2:0] OP_MUL    = 3'b100;
   localparam logic [2:0] OP_MULADD = 3'b101;
   localparam logic [2:0] OP_MULSUB = 3'b110;

   ////////////////////////////////////////////////////////////
   // register map, word addresses
   ////////////////////////////////////////////////////////////
   localparam logic [WB_ADR_W-1:0] REG_CTRL     = 10'h000;
   localparam logic [WB_ADR_W-1:0] REG_STATUS   = 10'h001;
   localparam logic [WB_ADR_W-1:0] REG_PROG_LEN = 10'h002;
   localparam logic [WB_ADR_W-1:0] DATA_BASE    = 10'h100;   // 0x100..0x1ff

   localparam logic [PLEN_W-1:0] PROG_LEN_RST = 9'd32;

   typedef struct packed {
      logic signed [HALF_W-1:0] re;
      logic signed [HALF_W-1:0] im;
   } cplx_t;

   // same word seen raw by bus and storage, as re/im by the datapath
   typedef union packed {
      logic [DATA_W-1:0] raw;
      cplx_t             c;
   } cword_u;

endpackage

`default_nettype wire

/* rtl/inst_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
   input  logic                        clk,
   input  logic                        en,
   input  logic [cfft_pkg::ADDR_W-1:0] addr,
   output logic [cfft_pkg::INST_W-1:0] data_out
);
   import cfft_pkg::*;

   // word layout  op,k | b | a | dst
   always_ff @(posedge clk) begin
      if (en) begin
         case (addr)
            // inputs times twiddles
            8'h00: data_out <= 32'h8020_0040;
            8'h01: data_out <= 32'h8021_0141;
            8'h02: data_out <= 32'h8022_0242;
            8'h03: data_out <= 32'h8023_0343;
            8'h04: data_out <= 32'h8024_0444;
            8'h05: data_out <= 32'h8025_0545;
            8'h06: data_out <= 32'h8026_0646;
            8'h07: data_out <= 32'h8027_0747;
            // stage 1 butterflies
            8'h08: data_out <= 32'hB044_4048;
            8'h09: data_out <= 32'hD044_4049;
            8'h0A: data_out <= 32'hB046_424A;
            8'h0B: data_out <= 32'hD046_424B;
            8'h0C: data_out <= 32'hB045_414C;
            8'h0D: data_out <= 32'hD045_414D;
            8'h0E: data_out <= 32'hB047_434E;
            8'h0F: data_out <= 32'hD047_434F;
            // stage 2
            8'h10: data_out <= 32'hB04A_4850;
            8'h11: data_out <= 32'hD04A_4852;
            8'h12: data_out <= 32'hB24B_4951;
            8'h13: data_out <= 32'hD24B_4953;
            8'h14: data_out <= 32'hB04E_4C54;
            8'h15: data_out <= 32'hD04E_4C56;
            8'h16: data_out <= 32'hB24F_4D55;
            8'h17: data_out <= 32'hD24F_4D57;
            // stage 3, results in 0x58..0x5f
            8'h18: data_out <= 32'hB054_5058;
            8'h19: data_out <= 32'hD054_505C;
            8'h1A: data_out <= 32'hB156_5259;
            8'h1B: data_out <= 32'hD156_525D;
            8'h1C: data_out <= 32'hB255_515A;
            8'h1D: data_out <= 32'hD255_515E;
            8'h1E: data_out <= 32'hB357_535B;
            8'h1F: data_out <= 32'hD357_535F;
            default: data_out <= {OP_NOP, {(INST_W-3){1'b0}}};
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/cdata_file.sv */
`timescale 1ns/1ps
`default_nettype none

module cdata_file (
   input  logic                        clk,
   input  logic [cfft_pkg::ADDR_W-1:0] rd_adr_a,
   input  logic [cfft_pkg::ADDR_W-1:0] rd_adr_b,
   output logic [cfft_pkg::DATA_W-1:0] rd_data_a,
   output logic [cfft_pkg::DATA_W-1:0] rd_data_b,
   input  logic [cfft_pkg::ADDR_W-1:0] host_radr,
   output logic [cfft_pkg::DATA_W-1:0] host_rdata,
   input  logic                        eng_we,
   input  logic [cfft_pkg::ADDR_W-1:0] eng_adr,
   input  logic [cfft_pkg::DATA_W-1:0] eng_wdat,
   input  logic                        host_we,
   input  logic [cfft_pkg::ADDR_W-1:0] host_adr,
   input  logic [cfft_pkg::DATA_W-1:0] host_wdat
);
   import cfft_pkg::*;

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic              wr_en;
   logic [ADDR_W-1:0] wr_adr;
   logic [DATA_W-1:0] wr_dat;

   // one write port, engine first
   assign wr_en  = eng_we || host_we;
   assign wr_adr = eng_we ? eng_adr : host_adr;
   assign wr_dat = eng_we ? eng_wdat : host_wdat;

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_adr] <= wr_dat;
   end

   // registered reads, old word on same-cycle write
   always_ff @(posedge clk) begin
      rd_data_a  <= mem[rd_adr_a];
      rd_data_b  <= mem[rd_adr_b];
      host_rdata <= mem[host_radr];
   end

endmodule

`default_nettype wire

/* rtl/cmac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module cmac_unit (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  logic [2:0]       op,
   input  logic [1:0]       rot,
   input  cfft_pkg::cword_u opa,
   input  cfft_pkg::cword_u opb,
   output logic             out_valid,
   output cfft_pkg::cword_u result
);
   import cfft_pkg::*;

   localparam int ROT_W  = HALF_W + 1;        // room for -(-1.0)
   localparam int PROD_W = 2 * HALF_W + 2;

   localparam logic signed [PROD_W-1:0] SAT_MAX = 2**(HALF_W-1) - 1;
   localparam logic signed [PROD_W-1:0] SAT_MIN = -(2**(HALF_W-1));
   localparam logic signed [PROD_W-1:0] RND     = 2**(FRAC_BITS-1);

   logic signed [HALF_W-1:0] a_re, a_im, b_re, b_im;
   logic signed [ROT_W-1:0]  rb_re, rb_im;
   logic signed [PROD_W-1:0] p_re, p_im;
   logic                     s1_valid;
   logic                     s1_mul;
   logic                     s1_sub;
   logic signed [PROD_W-1:0] s1_re, s1_im;
   logic signed [HALF_W-1:0] s1_a_re, s1_a_im;
   logic signed [PROD_W-1:0] v_re, v_im;

   function automatic logic signed [HALF_W-1:0] sat(input logic signed [PROD_W-1:0] v);
      if (v > SAT_MAX)
         return SAT_MAX[HALF_W-1:0];
      else if (v < SAT_MIN)
         return SAT_MIN[HALF_W-1:0];
      else
         return v[HALF_W-1:0];
   endfunction

   assign a_re = opa.c.re;
   assign a_im = opa.c.im;
   assign b_re = opb.c.re;
   assign b_im = opb.c.im;

   // b * (-j)^k, swap and negate only
   always_comb begin
      case (rot)
         2'd1: begin
            rb_re = b_im;
            rb_im = -b_re;
         end
         2'd2: begin
            rb_re = -b_re;
            rb_im = -b_im;
         end
         2'd3: begin
            rb_re = -b_im;
            rb_im = b_re;
         end
         default: begin
            rb_re = b_re;
            rb_im = b_im;
         end
      endcase
   end

   assign p_re = a_re * rb_re - a_im * rb_im;
   assign p_im = a_re * rb_im + a_im * rb_re;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         s1_valid  <= in_valid;
         out_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_mul  <= (op == OP_MUL);
      s1_sub  <= (op == OP_MULSUB);
      s1_re   <= (op == OP_MUL) ? p_re : rb_re;   // rot(b) passes through
      s1_im   <= (op == OP_MUL) ? p_im : rb_im;
      s1_a_re <= a_re;
      s1_a_im <= a_im;
   end

   // stage 2: round half up, or add/sub against a
   always_comb begin
      if (s1_mul) begin
         v_re = (s1_re + RND) >>> FRAC_BITS;
         v_im = (s1_im + RND) >>> FRAC_BITS;
      end else if (s1_sub) begin
         v_re = s1_a_re - s1_re;
         v_im = s1_a_im - s1_im;
      end else begin
         v_re = s1_a_re + s1_re;
         v_im = s1_a_im + s1_im;
      end
   end

   always_ff @(posedge clk) begin
      result.c.re <= sat(v_re);
      result.c.im <= sat(v_im);
   end

endmodule

`default_nettype wire

/* rtl/seq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        start,
   input  logic [cfft_pkg::PLEN_W-1:0] prog_len,
   output logic                        busy,
   output logic                        done,
   output logic                        rom_en,
   output logic [cfft_pkg::ADDR_W-1:0] rom_addr,
   input  logic [cfft_pkg::INST_W-1:0] rom_data,
   output logic [cfft_pkg::ADDR_W-1:0] rd_adr_a,
   output logic [cfft_pkg::ADDR_W-1:0] rd_adr_b,
   input  logic [cfft_pkg::DATA_W-1:0] rd_data_a,
   input  logic [cfft_pkg::DATA_W-1:0] rd_data_b,
   output logic                        eng_we,
   output logic [cfft_pkg::ADDR_W-1:0] eng_adr,
   output logic [cfft_pkg::DATA_W-1:0] eng_wdat
);
   import cfft_pkg::*;

   // dst is decoded at T1, the line covers T2 up to write-back
   localparam int DL = PIPE_LAT - 1;

   logic [PLEN_W-1:0] issue_cnt;
   logic [PLEN_W-1:0] retire_cnt;
   logic              issue;
   logic              word_vld;               // rom_data is live (T1)
   logic              op_vld;                 // operands on read ports (T2)
   logic [2:0]        dec_op;
   logic              dec_wr;
   logic [2:0]        op_q;
   logic [1:0]        rot_q;
   logic [ADDR_W-1:0] dst_q [DL];
   logic [DL-1:0]     wr_q;
   cword_u            opa, opb, mac_res;
   logic              mac_vld;
   logic              last;

   ////////////////////////////////////////////////////////////
   // issue and retire
   ////////////////////////////////////////////////////////////
   assign issue    = busy && (issue_cnt < prog_len);
   assign rom_en   = issue;
   assign rom_addr = issue_cnt[ADDR_W-1:0];
   assign last     = mac_vld && (retire_cnt == prog_len - 1'b1);
   assign done     = last;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         issue_cnt  <= '0;
         retire_cnt <= '0;
      end else if (start && !busy) begin
         busy       <= 1'b1;
         issue_cnt  <= '0;
         retire_cnt <= '0;
      end else begin
         if (issue)
            issue_cnt <= issue_cnt + 1'b1;
         if (mac_vld)
            retire_cnt <= retire_cnt + 1'b1;
         if (last)
            busy <= 1'b0;                     // falls with the last write-back
      end
   end

   ////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////
   assign dec_op   = rom_data[31:29];
   assign rd_adr_a = rom_data[15:8];
   assign rd_adr_b = rom_data[23:16];

   always_comb begin
      case (dec_op)
         OP_MUL, OP_MULADD, OP_MULSUB: dec_wr = 1'b1;
         default: dec_wr = 1'b0;              // nop retires silently
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_vld <= 1'b0;
         op_vld   <= 1'b0;
         wr_q     <= '0;
      end else begin
         word_vld <= issue;
         op_vld   <= word_vld;
         wr_q     <= {wr_q[DL-2:0], word_vld && dec_wr};
      end
   end

   always_ff @(posedge clk) begin
      op_q     <= dec_op;
      rot_q    <= rom_data[25:24];
      dst_q[0] <= rom_data[7:0];
      for (int i = 1; i < DL; i++)
         dst_q[i] <= dst_q[i-1];
   end

   assign opa.raw = rd_data_a;
   assign opb.raw = rd_data_b;

   cmac_unit u_mac (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (op_vld),
      .op        (op_q),
      .rot       (rot_q),
      .opa       (opa),
      .opb       (opb),
      .out_valid (mac_vld),
      .result    (mac_res)
   );

   assign eng_we   = mac_vld && wr_q[DL-1];
   assign eng_adr  = dst_q[DL-1];
   assign eng_wdat = mac_res.raw;

endmodule

`default_nettype wire

/* rtl/cfft_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cfft_regs (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [cfft_pkg::WB_ADR_W-1:0] wb_adr,
   input  logic [cfft_pkg::DATA_W-1:0]   wb_dat_w,
   output logic [cfft_pkg::DATA_W-1:0]   wb_dat_r,
   output logic                          wb_ack,
   output logic                          start,
   output logic [cfft_pkg::PLEN_W-1:0]   prog_len,
   input  logic                          busy,
   input  logic                          done,
   output logic                          host_we,
   output logic [cfft_pkg::ADDR_W-1:0]   host_adr,
   output logic [cfft_pkg::DATA_W-1:0]   host_wdat,
   output logic [cfft_pkg::ADDR_W-1:0]   host_radr,
   input  logic [cfft_pkg::DATA_W-1:0]   host_rdata
);
   import cfft_pkg::*;

   logic              req;
   logic              accept;                 // first cycle of an access
   logic              data_pend;              // window read waiting on the file
   logic              is_data;
   logic              len_ok;
   logic              done_q;
   logic [DATA_W-1:0] reg_rdat;

   ////////////////////////////////////////////////////////////
   // bus decode
   ////////////////////////////////////////////////////////////
   assign req     = wb_cyc && wb_stb;
   assign accept  = req && !wb_ack && !data_pend;
   assign is_data = (wb_adr[WB_ADR_W-1:ADDR_W] == DATA_BASE[WB_ADR_W-1:ADDR_W]);
   assign len_ok  = (wb_dat_w[PLEN_W-1:0] >= 1) && (wb_dat_w[PLEN_W-1:0] <= 2**ADDR_W);

   assign host_adr  = wb_adr[ADDR_W-1:0];
   assign host_radr = wb_adr[ADDR_W-1:0];
   assign host_wdat = wb_dat_w;
   assign host_we   = accept && wb_we && is_data && !busy;   // dropped while running

   always_comb begin
      case (wb_adr)
         REG_STATUS:   reg_rdat = {{(DATA_W-2){1'b0}}, done_q, busy};
         REG_PROG_LEN: reg_rdat = {{(DATA_W-PLEN_W){1'b0}}, prog_len};
         default:      reg_rdat = '0;         // ctrl and holes read 0
      endcase
   end

   // registers ack after 1, the window after 2
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_ack    <= 1'b0;
         data_pend <= 1'b0;
      end else begin
         wb_ack    <= (accept && !is_data) || (data_pend && req);
         data_pend <= accept && is_data;
      end
   end

   always_ff @(posedge clk) begin
      if (data_pend)
         wb_dat_r <= host_rdata;
      else if (accept)
         wb_dat_r <= reg_rdat;
   end

   ////////////////////////////////////////////////////////////
   // control and status
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start    <= 1'b0;
         prog_len <= PROG_LEN_RST;
         done_q   <= 1'b0;
      end else begin
         start <= accept && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0] && !busy;
         if (accept && wb_we && (wb_adr == REG_PROG_LEN) && !busy && len_ok)
            prog_len <= wb_dat_w[PLEN_W-1:0];
         if (start)
            done_q <= 1'b0;
         else if (done)
            done_q <= 1'b1;                   // sticky
      end
   end

endmodule

`default_nettype wire

/* rtl/cfft_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cfft_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [cfft_pkg::WB_ADR_W-1:0] wb_adr,
   input  logic [cfft_pkg::DATA_W-1:0]   wb_dat_w,
   output logic [cfft_pkg::DATA_W-1:0]   wb_dat_r,
   output logic                          wb_ack
);
   import cfft_pkg::*;

   logic              start;
   logic [PLEN_W-1:0] prog_len;
   logic              busy;
   logic              done;
   logic              host_we;
   logic [ADDR_W-1:0] host_adr;
   logic [DATA_W-1:0] host_wdat;
   logic [ADDR_W-1:0] host_radr;
   logic [DATA_W-1:0] host_rdata;
   logic              rom_en;
   logic [ADDR_W-1:0] rom_addr;
   logic [INST_W-1:0] rom_data;
   logic [ADDR_W-1:0] rd_adr_a;
   logic [ADDR_W-1:0] rd_adr_b;
   logic [DATA_W-1:0] rd_data_a;
   logic [DATA_W-1:0] rd_data_b;
   logic              eng_we;
   logic [ADDR_W-1:0] eng_adr;
   logic [DATA_W-1:0] eng_wdat;

   cfft_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .start      (start),
      .prog_len   (prog_len),
      .busy       (busy),
      .done       (done),
      .host_we    (host_we),
      .host_adr   (host_adr),
      .host_wdat  (host_wdat),
      .host_radr  (host_radr),
      .host_rdata (host_rdata)
   );

   seq_ctrl u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .prog_len  (prog_len),
      .busy      (busy),
      .done      (done),
      .rom_en    (rom_en),
      .rom_addr  (rom_addr),
      .rom_data  (rom_data),
      .rd_adr_a  (rd_adr_a),
      .rd_adr_b  (rd_adr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .eng_we    (eng_we),
      .eng_adr   (eng_adr),
      .eng_wdat  (eng_wdat)
   );

   inst_rom u_rom (
      .clk      (clk),
      .en       (rom_en),
      .addr     (rom_addr),
      .data_out (rom_data)
   );

   cdata_file u_dfile (
      .clk        (clk),
      .rd_adr_a   (rd_adr_a),
      .rd_adr_b   (rd_adr_b),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .host_radr  (host_radr),
      .host_rdata (host_rdata),
      .eng_we     (eng_we),
      .eng_adr    (eng_adr),
      .eng_wdat   (eng_wdat),
      .host_we    (host_we),
      .host_adr   (host_adr),
      .host_wdat  (host_wdat)
   );

endmodule

`default_nettype wire

/* sim/cfft_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cfft_sva (
   input logic clk,
   input logic rst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic busy,
   input logic done_st
);

   int fail_cnt = 0;

   ////////////////////////////////////////////////////////////
   // bus
   ////////////////////////////////////////////////////////////
   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else begin
         fail_cnt++;
         $error("ack seen outside an active bus cycle");
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else begin
         fail_cnt++;
         $error("ack held longer than one cycle");
      end

   ////////////////////////////////////////////////////////////
   // status
   ////////////////////////////////////////////////////////////
   idle_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !busy)
      else begin
         fail_cnt++;
         $error("busy set right after reset");
      end

   // sticky done sets on the edge where busy drops
   done_at_end: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(busy) |-> $rose(done_st))
      else begin
         fail_cnt++;
         $error("busy fell without done rising");
      end

   done_only_at_end: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(done_st) |-> $fell(busy))
      else begin
         fail_cnt++;
         $error("done rose while busy did not fall");
      end

endmodule

`default_nettype wire

/* sim/cfft_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cfft_tb;
   import cfft_pkg::*;

   localparam int CLK_NS   = 4;
   localparam int MAX_POLL = 300;
   // five runs of 256 issues, ~600 bus accesses of up to 4 cycles, a third extra
   localparam int WATCHDOG_NS = (5 * 256 + 600 * 4) * CLK_NS * 4 / 3;

   logic                clk;
   logic                rst_n;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [WB_ADR_W-1:0] wb_adr;
   logic [DATA_W-1:0]   wb_dat_w;
   logic [DATA_W-1:0]   wb_dat_r;
   logic                wb_ack;

   int errors = 0;

   logic [DATA_W-1:0] model_mem [2**ADDR_W];
   logic [2:0]        prog_op   [32];
   logic [1:0]        prog_k    [32];
   logic [ADDR_W-1:0] prog_a    [32];
   logic [ADDR_W-1:0] prog_b    [32];
   logic [ADDR_W-1:0] prog_d    [32];

   cfft_top DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   bind cfft_top cfft_sva u_sva (
      .clk     (clk),
      .rst_n   (rst_n),
      .wb_cyc  (wb_cyc),
      .wb_stb  (wb_stb),
      .wb_ack  (wb_ack),
      .busy    (busy),
      .done_st (u_regs.done_q)
   );

   initial clk = 1'b0;
   always #(CLK_NS / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // bus
   ////////////////////////////////////////////////////////////
   task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
      int n;
      n        = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!wb_ack && n < 8);
      rdat = wb_dat_r;
      if (!wb_ack) begin
         errors++;
         $display("bus access to address %h was never acknowledged", adr);
      end else begin
         @(posedge clk);                      // hold until ack is sampled
         #1;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
      logic [DATA_W-1:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read(input logic [WB_ADR_W-1:0] adr, output logic [DATA_W-1:0] dat);
      bus_access(1'b0, adr, '0, dat);
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] got);
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, got);
      end
   endtask

   task automatic expect_read(input string name, input logic [WB_ADR_W-1:0] adr,
                              input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] got;
      bus_read(adr, got);
      check_word(name, exp, got);
   endtask

   task automatic load_word(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] val);
      bus_write(DATA_BASE + WB_ADR_W'(adr), val);
      model_mem[adr] = val;
   endtask

   task automatic wait_done(input string name);
      logic [DATA_W-1:0] st;
      int n;
      n = 0;
      do begin
         bus_read(REG_STATUS, st);
         n++;
      end while (!st[1] && n < MAX_POLL);
      if (!st[1]) begin
         errors++;
         $display("%s: the run never reported done", name);
      end
      check_word({name, " status"}, 32'h2, st);
   endtask

   task automatic run_and_wait(input string name);
      bus_write(REG_CTRL, 32'h1);
      wait_done(name);
   endtask

   task automatic compare_range(input string name, input int lo, input int hi);
      for (int i = lo; i <= hi; i++)
         expect_read(name, DATA_BASE + WB_ADR_W'(i), model_mem[i]);
   endtask

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////
   function automatic logic [HALF_W-1:0] sat16(input longint v);
      if (v > 32767)
         return 16'h7FFF;
      else if (v < -32768)
         return 16'h8000;
      return v[15:0];
   endfunction

   function automatic logic [DATA_W-1:0] apply_op(input logic [2:0] op, input logic [1:0] k,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
      longint ar, ai, br, bi, t, vr, vi;
      ar = longint'($signed(a[31:16]));
      ai = longint'($signed(a[15:0]));
      br = longint'($signed(b[31:16]));
      bi = longint'($signed(b[15:0]));
      for (int n = 0; n < k; n++) begin      // each step times -j
         t  = br;
         br = bi;
         bi = -t;
      end
      case (op)
         OP_MUL: begin
            vr = (ar * br - ai * bi + (longint'(1) << (FRAC_BITS - 1))) >>> FRAC_BITS;
            vi = (ar * bi + ai * br + (longint'(1) << (FRAC_BITS - 1))) >>> FRAC_BITS;
         end
         OP_MULADD: begin
            vr = ar + br;
            vi = ai + bi;
         end
         default: begin
            vr = ar - br;
            vi = ai - bi;
         end
      endcase
      return {sat16(vr), sat16(vi)};
   endfunction

   task automatic put_inst(input int idx, input logic [2:0] op, input logic [1:0] k,
                           input logic [7:0] a, input logic [7:0] b, input logic [7:0] d);
      prog_op[idx] = op;
      prog_k[idx]  = k;
      prog_a[idx]  = a;
      prog_b[idx]  = b;
      prog_d[idx]  = d;
   endtask

   task automatic put_bfly(input int idx, input logic [7:0] a, input logic [7:0] b,
                           input logic [1:0] k, input logic [7:0] d_add, input logic [7:0] d_sub);
      put_inst(idx, OP_MULADD, k, a, b, d_add);
      put_inst(idx + 1, OP_MULSUB, k, a, b, d_sub);
   endtask

   task automatic build_program();
      for (int i = 0; i < 8; i++)
         put_inst(i, OP_MUL, 2'd0, 8'(i), 8'(8'h20 + i), 8'(8'h40 + i));
      // stage 1
      put_bfly(8,  8'h40, 8'h44, 2'd0, 8'h48, 8'h49);
      put_bfly(10, 8'h42, 8'h46, 2'd0, 8'h4A, 8'h4B);
      put_bfly(12, 8'h41, 8'h45, 2'd0, 8'h4C, 8'h4D);
      put_bfly(14, 8'h43, 8'h47, 2'd0, 8'h4E, 8'h4F);
      // stage 2
      put_bfly(16, 8'h48, 8'h4A, 2'd0, 8'h50, 8'h52);
      put_bfly(18, 8'h49, 8'h4B, 2'd2, 8'h51, 8'h53);
      put_bfly(20, 8'h4C, 8'h4E, 2'd0, 8'h54, 8'h56);
      put_bfly(22, 8'h4D, 8'h4F, 2'd2, 8'h55, 8'h57);
      // stage 3
      put_bfly(24, 8'h50, 8'h54, 2'd0, 8'h58, 8'h5C);
      put_bfly(26, 8'h52, 8'h56, 2'd1, 8'h59, 8'h5D);
      put_bfly(28, 8'h51, 8'h55, 2'd2, 8'h5A, 8'h5E);
      put_bfly(30, 8'h53, 8'h57, 2'd3, 8'h5B, 8'h5F);
   endtask

   task automatic model_run(input int len);
      for (int i = 0; i < len && i < 32; i++) begin
         if (prog_op[i] != OP_NOP)
            model_mem[prog_d[i]] = apply_op(prog_op[i], prog_k[i],
                                            model_mem[prog_a[i]], model_mem[prog_b[i]]);
      end
   endtask

   function automatic logic [DATA_W-1:0] rand_small();
      int re, im;
      re = int'($urandom_range(16383)) - 8192;
      im = int'($urandom_range(16383)) - 8192;
      return {re[15:0], im[15:0]};
   endfunction

   function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] adr);
      return {~adr, adr, adr ^ 8'hA5, adr};
   endfunction

   task automatic load_random_inputs();
      for (int i = 0; i < 8; i++) begin
         load_word(ADDR_W'(i), rand_small());
         load_word(ADDR_W'(8'h20 + i), rand_small());
      end
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////
   initial begin
      logic [DATA_W-1:0] keep;
      int total;
      void'($urandom(32'hb4b43238));
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      build_program();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // registers after reset
      expect_read("reset status", REG_STATUS, 32'h0);
      expect_read("reset prog_len", REG_PROG_LEN, 32'd32);
      bus_write(REG_PROG_LEN, 32'd100);
      expect_read("prog_len readback", REG_PROG_LEN, 32'd100);
      expect_read("unmapped 0x003", 10'h003, 32'h0);
      expect_read("unmapped 0x0ff", 10'h0FF, 32'h0);
      expect_read("unmapped 0x2a5", 10'h2A5, 32'h0);
      bus_write(REG_PROG_LEN, 32'd32);

      // data window
      for (int i = 0; i < 16; i++)
         load_word(ADDR_W'(8'h80 + i), $urandom());
      compare_range("window readback", 8'h80, 8'h8F);

      // full program, small values
      load_random_inputs();
      model_run(32);
      run_and_wait("fft small");
      compare_range("fft small", 8'h40, 8'h5F);

      // full scale, twiddles near 1.0
      for (int i = 0; i < 8; i++) begin
         load_word(ADDR_W'(i), (i < 4) ? 32'h7FFF_8000 : 32'h8000_7FFF);
         load_word(ADDR_W'(8'h20 + i), 32'h7FFF_0000);
      end
      model_run(32);
      run_and_wait("fft full scale");
      compare_range("fft full scale", 8'h40, 8'h5F);
      expect_read("mulsub saturation", DATA_BASE + 10'h49, 32'h7FFF_8000);
      expect_read("muladd saturation", DATA_BASE + 10'h5B, 32'h7FFF_FFFF);

      // short program leaves later words alone
      bus_write(REG_PROG_LEN, 32'd8);
      for (int i = 8'h48; i <= 8'h5F; i++)
         load_word(ADDR_W'(i), fill_pattern(ADDR_W'(i)));
      load_random_inputs();
      model_run(8);
      run_and_wait("prog_len 8");
      compare_range("prog_len 8", 8'h40, 8'h5F);
      bus_write(REG_PROG_LEN, 32'd32);

      // host writes and start while running
      load_random_inputs();
      model_run(32);
      keep = model_mem[5];
      bus_write(REG_CTRL, 32'h1);
      expect_read("status while busy", REG_STATUS, 32'h1);
      bus_write(DATA_BASE + 10'h005, ~keep);
      bus_write(REG_CTRL, 32'h1);           // must be ignored
      wait_done("busy run");
      expect_read("write while busy", DATA_BASE + 10'h005, keep);
      compare_range("busy run", 8'h40, 8'h5F);
      expect_read("no second run", REG_STATUS, 32'h2);

      total = errors + DUT.u_sva.fail_cnt;
      $display("errors: %0d (checks %0d, assertions %0d)", total, errors, DUT.u_sva.fail_cnt);
      if (total == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
rtl/cfft_pkg.sv
rtl/inst_rom.sv
rtl/cdata_file.sv
rtl/cmac_unit.sv
rtl/seq_ctrl.sv
rtl/cfft_regs.sv
rtl/cfft_top.sv
sim/cfft_sva.sv
sim/cfft_tb.sv
